/* dv/data_mem_subsystem_tb.sv */
`timescale 1ns/1ns
`default_nettype none

// Table-driven and random test of the L1/L2 data memory subsystem
module data_mem_subsystem_tb
    import cache_geometry_pkg::*;
    import mem_access_pkg::*;
();

    localparam int TABLE_LEN   = 24;
    localparam int NUM_RANDOM  = 200;
    localparam int MAX_WAIT    = 20;                     // Cycles before done_o counts as lost
    localparam int HIT_LAT     = 2;                      // Request cycle to done_o
    localparam int MISS_LAT    = 3 + L2_READ_LATENCY;
    localparam int WATCHDOG_NS = (TABLE_LEN + NUM_RANDOM) * 10 * 8 + 2000;
    localparam logic [ADDR_WIDTH-1:0] STRAY_ADDR = 32'h0000_0015;
    localparam logic [DATA_WIDTH-1:0] STRAY_DATA = 32'hDEAD_BEEF;

    typedef enum logic [1:0] {
        OP_LD,                                           // Load
        OP_ST,                                           // Store
        OP_LDP                                           // Load with a stray req_i while busy
    } op_e;

    typedef struct packed {
        op_e                   op;
        logic [ADDR_WIDTH-1:0] addr;
        access_size_e          size;
        logic [DATA_WIDTH-1:0] data;
        logic                  exp_hit;
        logic [DATA_WIDTH-1:0] exp_data;
    } vec_t;

    logic                  clk;
    logic                  reset_i;
    logic                  req_i;
    logic                  wr_en_i;
    logic [ADDR_WIDTH-1:0] addr_i;
    logic [DATA_WIDTH-1:0] wr_data_i;
    access_size_e          size_i;
    logic                  busy_o;
    logic                  done_o;
    logic                  hit_o;
    logic [DATA_WIDTH-1:0] rd_data_o;

    vec_t vec_table [TABLE_LEN];
    logic [INDEX_BITS-1:0] rand_sets [3] = '{8'h07, 8'h33, 8'hA2};   // Few sets, many evictions

    // Reference models
    logic [DATA_WIDTH-1:0] mem_ref   [int];              // Sparse, missing word reads as zero
    logic [TAG_BITS-1:0]   tag_ref   [NUM_SETS][NUM_WAYS];
    logic                  valid_ref [NUM_SETS][NUM_WAYS];
    int                    age_ref   [NUM_SETS][NUM_WAYS];

    int err_count;
    int fail_count;
    int check_count;

    tb_clock_gen #(.PERIOD_NS(8)) clk_gen0 (.clk(clk));

    data_mem_subsystem dut0 (
        .clk       (clk),
        .reset_i   (reset_i),
        .req_i     (req_i),
        .wr_en_i   (wr_en_i),
        .addr_i    (addr_i),
        .wr_data_i (wr_data_i),
        .size_i    (size_i),
        .busy_o    (busy_o),
        .done_o    (done_o),
        .hit_o     (hit_o),
        .rd_data_o (rd_data_o)
    );

    function automatic void set_vec(input int idx, input op_e op, input logic [31:0] a,
                                    input access_size_e size, input logic [31:0] d,
                                    input logic h, input logic [31:0] e);
        vec_table[idx] = '{op, a, size, d, h, e};
    endfunction

    // Tag keeps the bits around the set index
    function automatic logic [TAG_BITS-1:0] tag_of(input logic [ADDR_WIDTH-1:0] a);
        return {a[ADDR_WIDTH-1:INDEX_BITS+LOWER_TAG_BITS], a[LOWER_TAG_BITS-1:0]};
    endfunction

    function automatic int set_of(input logic [ADDR_WIDTH-1:0] a);
        return int'(a[INDEX_BITS+LOWER_TAG_BITS-1:LOWER_TAG_BITS]);
    endfunction

    function automatic logic [DATA_WIDTH-1:0] lane_mask(input access_size_e size);
        case (size)
            SIZE_BYTE: return 32'h0000_00FF;
            SIZE_HALF: return 32'h0000_FFFF;
            SIZE_WORD: return 32'hFFFF_FFFF;
            default:   return 32'h0000_0000;
        endcase
    endfunction

    function automatic logic [DATA_WIDTH-1:0] read_word(input logic [ADDR_WIDTH-1:0] a);
        int key;
        key = int'(a[L2_ADDR_BITS-1:0]);                 // L2 decodes 12 bits
        if (mem_ref.exists(key)) return mem_ref[key];
        return '0;
    endfunction

    function automatic bit lookup_ref(input logic [ADDR_WIDTH-1:0] a, output int way);
        int s;
        s   = set_of(a);
        way = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way < 0 && valid_ref[s][w] && tag_ref[s][w] == tag_of(a)) way = w;   // First match
        end
        return way >= 0;
    endfunction

    // Oldest way, lowest number on a tie
    function automatic int pick_victim(input int s);
        int v;
        v = 0;
        for (int w = 1; w < NUM_WAYS; w++) begin
            if (age_ref[s][w] > age_ref[s][v]) v = w;
        end
        return v;
    endfunction

    function automatic void age_touch(input int s, input int way);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (w == way) age_ref[s][w] = 0;
            else if (age_ref[s][w] < NUM_WAYS - 1) age_ref[s][w]++;   // Saturates at 3
        end
    endfunction

    // Update models for one access and return what the DUT should answer
    task automatic predict_access(input logic wr, input logic [31:0] a, input access_size_e size,
                                  input logic [31:0] wdata, output logic exp_hit,
                                  output logic [31:0] exp_data);
        int s;
        int way;
        logic [31:0] word;
        s       = set_of(a);
        exp_hit = lookup_ref(a, way);
        if (!exp_hit) begin
            way = pick_victim(s);                        // Filled when L2 returns
            valid_ref[s][way] = 1'b1;
            tag_ref[s][way]   = tag_of(a);
        end
        age_touch(s, way);                               // First lookup, or the fill
        age_touch(s, way);                               // Re-lookup in the response cycle
        word = read_word(a);
        if (wr) begin
            word = (word & ~lane_mask(size)) | (wdata & lane_mask(size));
            mem_ref[int'(a[L2_ADDR_BITS-1:0])] = word;
            exp_data = word;                             // Store answers with the merged word
        end else begin
            exp_data = word & lane_mask(size);           // Zero-extended load
        end
    endtask

    // Called 1 ns after a rising edge
    task automatic issue_access(input logic wr, input logic [31:0] a, input access_size_e size,
                                input logic [31:0] wdata, input bit stray, output bit seen,
                                output logic got_hit, output logic [31:0] got_data,
                                output int lat);
        int cyc;
        seen     = 1'b0;
        got_hit  = 1'b0;
        got_data = '0;
        lat      = 0;
        cyc      = 0;
        while (busy_o) begin
            @(posedge clk);
            #1;
        end
        req_i     = 1'b1;
        wr_en_i   = wr;
        addr_i    = a;
        wr_data_i = wdata;
        size_i    = size;
        while (!seen && cyc < MAX_WAIT) begin
            @(posedge clk);
            #1;
            cyc++;
            if (cyc == 1 && !busy_o) begin
                fail_count++;
                $display("busy_o stayed low after a request to %h was accepted", a);
            end
            if (done_o) begin
                seen     = 1'b1;
                got_hit  = hit_o;
                got_data = rd_data_o;
                lat      = cyc;
            end
            if (cyc == 1 && stray) begin
                wr_en_i   = 1'b1;                        // req_i held one more cycle while busy
                addr_i    = STRAY_ADDR;
                wr_data_i = STRAY_DATA;
                size_i    = SIZE_WORD;
            end else begin
                req_i = 1'b0;
            end
        end
        if (seen) begin
            @(posedge clk);
            #1;
            if (done_o) begin
                fail_count++;
                $display("done_o stayed high or repeated after the access to %h", a);
            end
            if (busy_o) begin
                fail_count++;
                $display("busy_o still high one cycle after done_o for %h", a);
            end
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR t=%0t %s expected %08h got %08h", $time, name, exp, got);
        end
    endtask

    // One access checked against the models
    task automatic run_one(input logic wr, input logic [31:0] a, input access_size_e size,
                           input logic [31:0] wdata, input bit stray, output bit seen,
                           output logic got_hit, output logic [31:0] got_data);
        logic exp_hit;
        logic [31:0] exp_data;
        int lat;
        predict_access(wr, a, size, wdata, exp_hit, exp_data);
        issue_access(wr, a, size, wdata, stray, seen, got_hit, got_data, lat);
        if (!seen) begin
            fail_count++;
            $display("No done_o within %0d cycles for the access to %h", MAX_WAIT, a);
        end else begin
            compare_value("hit_o", {31'b0, exp_hit}, {31'b0, got_hit});
            compare_value("rd_data_o", exp_data, got_data);
            compare_value("done_o cycles", 32'(exp_hit ? HIT_LAT : MISS_LAT), 32'(lat));
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with accesses still running", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int seed_val;
        int sel;
        bit seen;
        logic got_hit;
        logic [31:0] got_data;
        logic r_wr;
        logic [1:0] hi;
        logic [1:0] lo;
        logic [31:0] r_addr;
        access_size_e r_size;
        seed_val    = $urandom(49197);
        err_count   = 0;
        fail_count  = 0;
        check_count = 0;
        reset_i     = 1'b1;
        req_i       = 1'b0;
        wr_en_i     = 1'b0;
        addr_i      = '0;
        wr_data_i   = '0;
        size_i      = SIZE_NONE;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_ref[s][w] = 1'b0;
                tag_ref[s][w]   = '0;
                age_ref[s][w]   = 0;
            end
        end

        // Set 5 takes five tags, set 0x10 the size and low-bit cases
        set_vec(0,  OP_LD,  32'h014, SIZE_WORD, 32'h0,        1'b0, 32'h0);   // Cold miss
        set_vec(1,  OP_LD,  32'h014, SIZE_WORD, 32'h0,        1'b1, 32'h0);
        set_vec(2,  OP_ST,  32'h014, SIZE_WORD, 32'h11223344, 1'b1, 32'h11223344);
        set_vec(3,  OP_ST,  32'h414, SIZE_WORD, 32'hA5A5A5A5, 1'b0, 32'hA5A5A5A5);
        set_vec(4,  OP_ST,  32'h814, SIZE_WORD, 32'h5A5A5A5A, 1'b0, 32'h5A5A5A5A);
        set_vec(5,  OP_ST,  32'hC14, SIZE_WORD, 32'hCAFEF00D, 1'b0, 32'hCAFEF00D); // Evicts 014
        set_vec(6,  OP_LD,  32'h014, SIZE_WORD, 32'h0,        1'b0, 32'h11223344);
        set_vec(7,  OP_LD,  32'h414, SIZE_WORD, 32'h0,        1'b0, 32'hA5A5A5A5);
        set_vec(8,  OP_LD,  32'h015, SIZE_WORD, 32'h0,        1'b0, 32'h0);
        set_vec(9,  OP_LD,  32'hC14, SIZE_WORD, 32'h0,        1'b0, 32'hCAFEF00D);
        set_vec(10, OP_LD,  32'h414, SIZE_HALF, 32'h0,        1'b1, 32'h0000A5A5);
        set_vec(11, OP_ST,  32'h040, SIZE_WORD, 32'h87654321, 1'b0, 32'h87654321);
        set_vec(12, OP_ST,  32'h040, SIZE_BYTE, 32'hFFFFFFAB, 1'b1, 32'h876543AB);
        set_vec(13, OP_LD,  32'h040, SIZE_BYTE, 32'h0,        1'b1, 32'h000000AB);
        set_vec(14, OP_LD,  32'h040, SIZE_HALF, 32'h0,        1'b1, 32'h000043AB);
        set_vec(15, OP_ST,  32'h040, SIZE_HALF, 32'h1234BEEF, 1'b1, 32'h8765BEEF);
        set_vec(16, OP_LD,  32'h040, SIZE_WORD, 32'h0,        1'b1, 32'h8765BEEF);
        set_vec(17, OP_ST,  32'h041, SIZE_BYTE, 32'h1234567E, 1'b0, 32'h0000007E); // Store miss
        set_vec(18, OP_ST,  32'h042, SIZE_HALF, 32'hFFFF9C9C, 1'b0, 32'h00009C9C);
        set_vec(19, OP_LD,  32'h041, SIZE_WORD, 32'h0,        1'b1, 32'h0000007E);
        set_vec(20, OP_LD,  32'h040, SIZE_WORD, 32'h0,        1'b1, 32'h8765BEEF);
        set_vec(21, OP_LD,  32'h043, SIZE_WORD, 32'h0,        1'b0, 32'h0);
        set_vec(22, OP_LDP, 32'h042, SIZE_WORD, 32'h0,        1'b0, 32'h00009C9C);
        set_vec(23, OP_LD,  32'h015, SIZE_WORD, 32'h0,        1'b1, 32'h0);   // Stray store lost

        repeat (4) @(posedge clk);
        #1;
        reset_i = 1'b0;

        for (int i = 0; i < TABLE_LEN; i++) begin
            run_one(vec_table[i].op == OP_ST, vec_table[i].addr, vec_table[i].size,
                    vec_table[i].data, vec_table[i].op == OP_LDP, seen, got_hit, got_data);
            if (seen) begin
                compare_value("hit_o (table)", {31'b0, vec_table[i].exp_hit}, {31'b0, got_hit});
                compare_value("rd_data_o (table)", vec_table[i].exp_data, got_data);
            end
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            hi     = 2'($urandom_range(0, 3));
            lo     = 2'($urandom_range(0, 3));
            r_addr = {20'b0, hi, rand_sets[$urandom_range(0, 2)], lo};   // Below 4096
            r_wr   = $urandom_range(0, 1) != 0;
            sel    = $urandom_range(0, 2);
            case (sel)
                0:       r_size = SIZE_BYTE;
                1:       r_size = SIZE_HALF;
                default: r_size = SIZE_WORD;
            endcase
            run_one(r_wr, r_addr, r_size, $urandom(), 1'b0, seen, got_hit, got_data);
        end

        $display("Checks %0d, value errors %0d, other failures %0d",
                 check_count, err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

// Free-running testbench clock, starts low
module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;   // 50% duty
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the data memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module data_mem_subsystem_tb -f sources.f

out=$(./obj_dir/Vdata_mem_subsystem_tb 2>&1) || { printf '%s\n' "$out"; exit 1; }
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

/* sources.f */
verilog/cache_geometry_pkg.sv
verilog/mem_access_pkg.sv
verilog/l1_4way_data_cache_4kb.sv
verilog/l2_backing_store.sv
verilog/l1_miss_controller.sv
verilog/data_mem_subsystem.sv
dv/tb_clock_gen.sv
dv/data_mem_subsystem_tb.sv

/* verilog/cache_geometry_pkg.sv */
`default_nettype none

// L1 geometry: 4 ways x 256 sets x one 32-bit word = 4 KB
//
//   addr_i  | tag high [31:10] | set index [9:2] | tag low [1:0] |
//   tag     = {addr_i[31:10], addr_i[1:0]}, 24 bits
//
// Bits 1:0 stay in the tag, so every address names its own word
package cache_geometry_pkg;

    localparam int ADDR_WIDTH     = 32;                      // Core address width
    localparam int DATA_WIDTH     = 32;                      // One word per line

    localparam int NUM_SETS       = 256;
    localparam int NUM_WAYS       = 4;
    localparam int WAY_BITS       = $clog2(NUM_WAYS);        // Way number width

    localparam int INDEX_BITS     = $clog2(NUM_SETS);        // Set index, addr[9:2]
    localparam int LOWER_TAG_BITS = 2;                       // addr[1:0] kept in tag
    localparam int TAG_BITS       = ADDR_WIDTH - INDEX_BITS; // 22 high + 2 low

    // Per-way age counter, saturates at NUM_WAYS-1
    localparam int AGE_BITS       = 3;

    // L2 backing store decodes the low word address bits only
    localparam int L2_ADDR_BITS   = 12;
    localparam int L2_DEPTH       = 1 << L2_ADDR_BITS;       // 4096 words

endpackage

`default_nettype wire

/* verilog/data_mem_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

// Core-facing data memory: controller, L1 cache, L2 store
module data_mem_subsystem
    import cache_geometry_pkg::*;
    import mem_access_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  req_i,
    input  wire logic                  wr_en_i,
    input  wire logic [ADDR_WIDTH-1:0] addr_i,
    input  wire logic [DATA_WIDTH-1:0] wr_data_i,
    input  wire access_size_e          size_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic                       hit_o,
    output logic      [DATA_WIDTH-1:0] rd_data_o
);

    // Controller to cache, shared with L2
    logic [ADDR_WIDTH-1:0] l1_addr;
    logic                  l1_wr_en;
    logic [DATA_WIDTH-1:0] l1_wr_data;
    access_size_e          l1_byte_en;

    logic                  l1_hit;
    logic [DATA_WIDTH-1:0] l1_rd_data;

    logic                  l2_wr_stb;
    logic                  l2_rd_stb;
    logic                  l2_valid;                   // To cache and controller
    logic [DATA_WIDTH-1:0] l2_data;

    l1_miss_controller u_ctrl (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_i        (req_i),
        .wr_en_i      (wr_en_i),
        .addr_i       (addr_i),
        .wr_data_i    (wr_data_i),
        .size_i       (size_i),
        .l1_hit_i     (l1_hit),
        .l1_rd_data_i (l1_rd_data),
        .l2_valid_i   (l2_valid),
        .l1_addr_o    (l1_addr),
        .l1_wr_en_o   (l1_wr_en),
        .l1_wr_data_o (l1_wr_data),
        .l1_byte_en_o (l1_byte_en),
        .l2_wr_stb_o  (l2_wr_stb),
        .l2_rd_stb_o  (l2_rd_stb),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .hit_o        (hit_o),
        .rd_data_o    (rd_data_o)
    );

    l1_4way_data_cache_4kb u_l1_cache (
        .clk              (clk),
        .reset_i          (reset_i),
        .wr_en_i          (l1_wr_en),
        .addr_i           (l1_addr),
        .wr_data_i        (l1_wr_data),
        .byte_en_i        (l1_byte_en),
        .l2_cache_valid_i (l2_valid),
        .l2_cache_data_i  (l2_data),
        .l1_rd_data_o     (l1_rd_data),
        .l1_cache_hit_o   (l1_hit)
    );

    // Held request doubles as the L2 address, data and lanes
    l2_backing_store u_l2_store (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_stb_i   (l2_wr_stb),
        .rd_stb_i   (l2_rd_stb),
        .addr_i     (l1_addr),
        .wr_data_i  (l1_wr_data),
        .byte_en_i  (l1_byte_en),
        .rd_valid_o (l2_valid),
        .rd_data_o  (l2_data)
    );

endmodule

`default_nettype wire

/* verilog/l1_4way_data_cache_4kb.sv */
`timescale 1ns/1ns
`default_nettype none

// 4-way set-associative L1 data cache, one word per line
module l1_4way_data_cache_4kb
    import cache_geometry_pkg::*;
    import mem_access_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  wr_en_i,          // Store access
    input  wire logic [ADDR_WIDTH-1:0] addr_i,           // Word address
    input  wire logic [DATA_WIDTH-1:0] wr_data_i,        // Store data, low lanes
    input  wire access_size_e          byte_en_i,        // SIZE_NONE keeps the cache idle
    input  wire logic                  l2_cache_valid_i, // Fill strobe from L2
    input  wire logic [DATA_WIDTH-1:0] l2_cache_data_i,  // Fill word
    output logic      [DATA_WIDTH-1:0] l1_rd_data_o,     // Zero-extended read data
    output logic                       l1_cache_hit_o
);

    // Line storage
    logic [TAG_BITS-1:0]   tag_array   [NUM_SETS][NUM_WAYS];
    logic [DATA_WIDTH-1:0] data_array  [NUM_SETS][NUM_WAYS];
    logic                  valid_array [NUM_SETS][NUM_WAYS];
    logic [AGE_BITS-1:0]   age_array   [NUM_SETS][NUM_WAYS];   // 0 = most recent

    logic [TAG_BITS-1:0]     tag;
    logic [INDEX_BITS-1:0]   set_idx;
    logic [DATA_WIDTH/8-1:0] lane_en;

    logic                  hit;
    logic [WAY_BITS-1:0]   hit_way;
    logic [DATA_WIDTH-1:0] hit_word;

    logic [WAY_BITS-1:0]   victim_way;
    logic [AGE_BITS-1:0]   victim_age;
    logic [DATA_WIDTH-1:0] fill_word;
    logic                  fill_en;

    logic                  touch_en;                      // Age update this cycle
    logic [WAY_BITS-1:0]   touch_way;

    // High tag bits above the index, low tag bits below it
    assign tag     = {addr_i[ADDR_WIDTH-1:INDEX_BITS+LOWER_TAG_BITS],
                      addr_i[LOWER_TAG_BITS-1:0]};
    assign set_idx = addr_i[INDEX_BITS+LOWER_TAG_BITS-1:LOWER_TAG_BITS];
    assign lane_en = byte_en_i;                           // Enum value is the lane mask

    // Lookup, first valid matching way wins
    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        hit_word = '0;
        if (byte_en_i != SIZE_NONE) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (!hit && valid_array[set_idx][w] && tag_array[set_idx][w] == tag) begin
                    hit      = 1'b1;
                    hit_way  = WAY_BITS'(w);
                    hit_word = data_array[set_idx][w];
                end
            end
        end
    end

    assign l1_cache_hit_o = hit;

    // Lane select with zero-extension, all zero on a miss
    always_comb begin
        case (byte_en_i)
            SIZE_BYTE: l1_rd_data_o = {{(DATA_WIDTH-8){1'b0}}, hit_word[7:0]};
            SIZE_HALF: l1_rd_data_o = {{(DATA_WIDTH-16){1'b0}}, hit_word[15:0]};
            SIZE_WORD: l1_rd_data_o = hit_word;
            default:   l1_rd_data_o = '0;
        endcase
    end

    // Victim is the oldest way
    // Strict compare keeps the lowest-numbered way on a tie
    always_comb begin
        victim_way = '0;
        victim_age = age_array[set_idx][0];
        for (int w = 1; w < NUM_WAYS; w++) begin
            if (age_array[set_idx][w] > victim_age) begin
                victim_way = WAY_BITS'(w);
                victim_age = age_array[set_idx][w];
            end
        end
    end

    // Fill word: L2 data with any store lanes laid over it
    always_comb begin
        for (int b = 0; b < DATA_WIDTH/8; b++) begin
            fill_word[8*b +: 8] = (wr_en_i && lane_en[b]) ? wr_data_i[8*b +: 8]
                                                          : l2_cache_data_i[8*b +: 8];
        end
    end

    assign fill_en   = l2_cache_valid_i && !hit;          // Only a missing line is filled
    assign touch_en  = hit || fill_en;
    assign touch_way = hit ? hit_way : victim_way;

    // Valid bits and ages
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    valid_array[s][w] <= 1'b0;
                    age_array[s][w]   <= '0;
                end
            end
        end else begin
            if (fill_en) begin
                valid_array[set_idx][victim_way] <= 1'b1;
            end
            if (touch_en) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    if (WAY_BITS'(w) == touch_way) begin
                        age_array[set_idx][w] <= '0;    // Most recently used
                    end else if (age_array[set_idx][w] < AGE_BITS'(NUM_WAYS - 1)) begin
                        age_array[set_idx][w] <= age_array[set_idx][w] + 1'b1;
                    end
                end
            end
        end
    end

    // Tags and data
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_array[set_idx][victim_way]  <= tag;
            data_array[set_idx][victim_way] <= fill_word;
        end else if (hit && wr_en_i) begin
            for (int b = 0; b < DATA_WIDTH/8; b++) begin
                if (lane_en[b]) begin
                    data_array[set_idx][hit_way][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

    // Only the four size codes are driven by the controller
    a_byte_en_legal: assert property (@(posedge clk) disable iff (reset_i)
        byte_en_i inside {SIZE_NONE, SIZE_BYTE, SIZE_HALF, SIZE_WORD});

    // L2 returns data only for an access that missed here
    a_fill_only_on_miss: assert property (@(posedge clk) disable iff (reset_i)
        l2_cache_valid_i |-> !hit);

endmodule

`default_nettype wire

/* verilog/l1_miss_controller.sv */
`timescale 1ns/1ns
`default_nettype none

// Sequences one core access through the L1 and the L2
module l1_miss_controller
    import cache_geometry_pkg::*;
    import mem_access_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  req_i,          // Strobe, taken only when idle
    input  wire logic                  wr_en_i,
    input  wire logic [ADDR_WIDTH-1:0] addr_i,
    input  wire logic [DATA_WIDTH-1:0] wr_data_i,
    input  wire access_size_e          size_i,
    input  wire logic                  l1_hit_i,
    input  wire logic [DATA_WIDTH-1:0] l1_rd_data_i,
    input  wire logic                  l2_valid_i,
    output logic      [ADDR_WIDTH-1:0] l1_addr_o,      // Also the L2 address
    output logic                       l1_wr_en_o,
    output logic      [DATA_WIDTH-1:0] l1_wr_data_o,   // Also the L2 write data
    output access_size_e               l1_byte_en_o,   // Also the L2 byte enable
    output logic                       l2_wr_stb_o,
    output logic                       l2_rd_stb_o,
    output logic                       busy_o,
    output logic                       done_o,
    output logic                       hit_o,          // First lookup result
    output logic      [DATA_WIDTH-1:0] rd_data_o
);

    ctrl_state_e           state_q, state_d;
    logic                  wr_en_q;
    logic                  hit_q;
    logic [ADDR_WIDTH-1:0] addr_q;                     // Held request
    logic [DATA_WIDTH-1:0] wr_data_q;
    access_size_e          size_q;
    logic                  accept;

    assign accept = req_i && (state_q == ST_IDLE);    // req_i while busy is dropped

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:    if (accept) state_d = ST_LOOKUP;
            ST_LOOKUP:  state_d = l1_hit_i ? ST_RESPOND : ST_L2_WAIT;
            ST_L2_WAIT: if (l2_valid_i) state_d = ST_RESPOND;   // Fill at this edge
            ST_RESPOND: state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            wr_en_q <= 1'b0;
            hit_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) wr_en_q <= wr_en_i;
            if (state_q == ST_LOOKUP) hit_q <= l1_hit_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q    <= addr_i;
            wr_data_q <= wr_data_i;
            size_q    <= size_i;
        end
    end

    // Cache drive per state
    always_comb begin
        l1_byte_en_o = SIZE_NONE;                      // Idle cache
        l1_wr_en_o   = 1'b0;
        case (state_q)
            ST_LOOKUP, ST_L2_WAIT: begin
                l1_byte_en_o = size_q;                 // Store lanes kept for the fill merge
                l1_wr_en_o   = wr_en_q;
            end
            // Read back; a store returns its whole merged word
            ST_RESPOND: l1_byte_en_o = wr_en_q ? SIZE_WORD : size_q;
            default:    l1_byte_en_o = SIZE_NONE;
        endcase
    end

    assign l1_addr_o    = addr_q;
    assign l1_wr_data_o = wr_data_q;
    assign l2_wr_stb_o  = (state_q == ST_LOOKUP) && wr_en_q;    // Every store goes through
    assign l2_rd_stb_o  = (state_q == ST_LOOKUP) && !l1_hit_i;  // Miss fetch

    assign busy_o    = (state_q != ST_IDLE);
    assign done_o    = (state_q == ST_RESPOND);
    assign hit_o     = hit_q;
    assign rd_data_o = l1_rd_data_i;                   // Valid with done_o

    a_done_single: assert property (@(posedge clk) disable iff (reset_i)
        done_o |=> !done_o);

    // L2 answers only the outstanding miss
    a_l2_valid_in_wait: assert property (@(posedge clk) disable iff (reset_i)
        l2_valid_i |-> state_q == ST_L2_WAIT);

    // And exactly on time
    a_l2_latency: assert property (@(posedge clk) disable iff (reset_i)
        l2_rd_stb_o |=> ##L2_READ_LATENCY l2_valid_i);

endmodule

`default_nettype wire

/* verilog/l2_backing_store.sv */
`timescale 1ns/1ns
`default_nettype none

// Word-addressed backing store behind the L1
module l2_backing_store
    import cache_geometry_pkg::*;
    import mem_access_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  wr_stb_i,     // Write-through, lands at this edge
    input  wire logic                  rd_stb_i,     // Starts a read
    input  wire logic [ADDR_WIDTH-1:0] addr_i,
    input  wire logic [DATA_WIDTH-1:0] wr_data_i,
    input  wire access_size_e          byte_en_i,
    output logic                       rd_valid_o,   // One-cycle pulse
    output logic      [DATA_WIDTH-1:0] rd_data_o
);

    logic [DATA_WIDTH-1:0]   mem [L2_DEPTH];
    logic [L2_ADDR_BITS-1:0] word_addr;
    logic [DATA_WIDTH/8-1:0] lane_en;

    // Read pipe, several reads may be in flight
    logic                    pipe_vld  [L2_READ_LATENCY];
    logic [L2_ADDR_BITS-1:0] pipe_addr [L2_READ_LATENCY];
    logic                    addr_in_flight;

    assign word_addr = addr_i[L2_ADDR_BITS-1:0];   // Upper bits not decoded
    assign lane_en   = byte_en_i;

    // Model power-up contents
    initial begin
        for (int i = 0; i < L2_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Byte-lane write
    always @(posedge clk) begin
        if (wr_stb_i) begin
            for (int b = 0; b < DATA_WIDTH/8; b++) begin
                if (lane_en[b]) begin
                    mem[word_addr][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

    // Strobe shift and the valid pulse
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < L2_READ_LATENCY; s++) begin
                pipe_vld[s] <= 1'b0;
            end
            rd_valid_o <= 1'b0;
        end else begin
            pipe_vld[0] <= rd_stb_i;
            for (int s = 1; s < L2_READ_LATENCY; s++) begin
                pipe_vld[s] <= pipe_vld[s-1];
            end
            rd_valid_o <= pipe_vld[L2_READ_LATENCY-1];
        end
    end

    // Address shift, last stage reads the array
    always_ff @(posedge clk) begin
        pipe_addr[0] <= word_addr;
        for (int s = 1; s < L2_READ_LATENCY; s++) begin
            pipe_addr[s] <= pipe_addr[s-1];
        end
        rd_data_o <= mem[pipe_addr[L2_READ_LATENCY-1]];
    end

    always_comb begin
        addr_in_flight = 1'b0;
        for (int s = 0; s < L2_READ_LATENCY; s++) begin
            if (pipe_vld[s] && pipe_addr[s] == word_addr) begin
                addr_in_flight = 1'b1;
            end
        end
    end

    // Only a read strobed with the write itself may share its address
    a_no_write_under_read: assert property (@(posedge clk) disable iff (reset_i)
        wr_stb_i |-> !addr_in_flight);

    // Callers stay inside the 4096-word window
    a_addr_in_range: assert property (@(posedge clk) disable iff (reset_i)
        (wr_stb_i || rd_stb_i) |-> addr_i[ADDR_WIDTH-1:L2_ADDR_BITS] == '0);

endmodule

`default_nettype wire

/* verilog/mem_access_pkg.sv */
`default_nettype none

// Access encodings and controller sequencing shared by the subsystem
package mem_access_pkg;

    // Byte enables in the low lanes, the value is the lane mask itself
    typedef enum logic [3:0] {
        SIZE_NONE = 4'b0000,   // No access, cache stays quiet
        SIZE_BYTE = 4'b0001,   // Lane 0
        SIZE_HALF = 4'b0011,   // Lanes 1:0
        SIZE_WORD = 4'b1111    // All lanes
    } access_size_e;

    // One access at a time
    typedef enum logic [1:0] {
        ST_IDLE,               // Waiting for req_i
        ST_LOOKUP,             // Tag compare, write-through, miss fetch
        ST_L2_WAIT,            // Miss outstanding in L2
        ST_RESPOND             // Re-lookup and done pulse
    } ctrl_state_e;

    // Clock edges from the edge that takes the L2 read strobe
    // to the edge that raises the L2 valid pulse
    localparam int L2_READ_LATENCY = 3;

endpackage

`default_nettype wire
